// ==== include/ext_mem_config.svh ====
`ifndef EXT_MEM_CONFIG_SVH
`define EXT_MEM_CONFIG_SVH

// Word address width, one extra bit on top of it selects control space
`define EXT_MEM_ADDR_W 10

// Data word width
`define EXT_MEM_DATA_W 32

// Line counts as log2, L1 caches and the shared L2
`define EXT_MEM_L1_LINES_W 3
`define EXT_MEM_L2_LINES_W 4

// Words per line as log2
`define EXT_MEM_WORD_OFF_W 2

// Cycle limit for a full simulation run
`define EXT_MEM_TIMEOUT 200000

`endif

// ==== source/ext_mem_pkg.sv ====
`include "ext_mem_config.svh"

package ext_mem_pkg;

   // Request toward a cache, the merger or memory
   typedef struct packed {
      logic                           valid;
      logic [`EXT_MEM_ADDR_W:0]       addr;  // Top bit selects control space
      logic [`EXT_MEM_DATA_W-1:0]     wdata;
      logic [`EXT_MEM_DATA_W/8-1:0]   wstrb; // All zero for a read
   } bus_req_t;

   // Response back to the requester
   // ready marks acceptance, rvalid carries read data
   typedef struct packed {
      logic                       ready;
      logic                       rvalid;
      logic [`EXT_MEM_DATA_W-1:0] rdata;
   } bus_rsp_t;

endpackage

// ==== source/word_cache.sv ====
`timescale 1ns/1ps
`include "ext_mem_config.svh"

module word_cache import ext_mem_pkg::*; #(
   parameter int LINES_W  = `EXT_MEM_L1_LINES_W,
   parameter bit HAS_CTRL = 1'b0
) (
   input  logic     clk_i,
   input  logic     arst_i,
   input  bus_req_t fe_req_i,
   output bus_rsp_t fe_rsp_o,
   output bus_req_t be_req_o,
   input  bus_rsp_t be_rsp_i,
   input  logic     inval_i,
   output logic     inval_o
);

   localparam int ADDR_W = `EXT_MEM_ADDR_W;
   localparam int DATA_W = `EXT_MEM_DATA_W;
   localparam int OFF_W  = `EXT_MEM_WORD_OFF_W;
   localparam int TAG_W  = ADDR_W - LINES_W - OFF_W;
   localparam int LINES  = 1 << LINES_W;
   localparam int WORDS  = LINES << OFF_W;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_REFILL,
      ST_WRITE
   } state_t;

   state_t state_q;
   state_t state_d;

   // Storage
   logic [DATA_W-1:0]  data_q [WORDS];
   logic [TAG_W-1:0]   tag_q  [LINES];
   logic [LINES-1:0]   valid_q;

   logic [ADDR_W-1:0]  addr_q;  // Address of the read in progress
   logic [OFF_W-1:0]   cnt_q;   // Next refill word
   logic               wait_q;  // Refill read accepted, data pending

   // Latched read split into fields
   logic [TAG_W-1:0]   rd_tag;
   logic [LINES_W-1:0] rd_idx;
   logic [OFF_W-1:0]   rd_off;
   logic               rd_hit;

   // Front-end write split into fields
   logic [TAG_W-1:0]   wr_tag;
   logic [LINES_W-1:0] wr_idx;
   logic [OFF_W-1:0]   wr_off;
   logic               wr_hit;
   logic [DATA_W-1:0]  wr_word;

   logic fe_is_write;
   logic fe_is_ctrl;
   logic rd_accept;
   logic wr_accept;
   logic ctrl_accept;
   logic refill_req;
   logic refill_word;
   logic refill_last;

   assign rd_tag = addr_q[ADDR_W-1 -: TAG_W];
   assign rd_idx = addr_q[OFF_W +: LINES_W];
   assign rd_off = addr_q[OFF_W-1:0];
   assign rd_hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

   assign wr_tag = fe_req_i.addr[ADDR_W-1 -: TAG_W];
   assign wr_idx = fe_req_i.addr[OFF_W +: LINES_W];
   assign wr_off = fe_req_i.addr[OFF_W-1:0];
   assign wr_hit = valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

   assign fe_is_write = |fe_req_i.wstrb;
   assign fe_is_ctrl  = HAS_CTRL && fe_req_i.addr[ADDR_W]; // Only the data cache decodes it

   // Stored word with the written bytes merged in
   always_comb begin
      wr_word = data_q[{wr_idx, wr_off}];
      for (int b = 0; b < DATA_W/8; b++) begin
         if (fe_req_i.wstrb[b]) begin
            wr_word[8*b +: 8] = fe_req_i.wdata[8*b +: 8];
         end
      end
   end

   always_comb begin
      state_d     = state_q;
      fe_rsp_o    = '0;
      be_req_o    = '0;
      inval_o     = 1'b0;
      rd_accept   = 1'b0;
      wr_accept   = 1'b0;
      ctrl_accept = 1'b0;
      case (state_q)
         ST_IDLE: begin
            if (fe_req_i.valid) begin
               if (!fe_is_write) begin
                  fe_rsp_o.ready = 1'b1;
                  rd_accept      = 1'b1;
                  state_d        = ST_LOOKUP;
               end else if (fe_is_ctrl) begin
                  fe_rsp_o.ready = 1'b1; // Control write, flush everything
                  inval_o        = 1'b1;
                  ctrl_accept    = 1'b1;
               end else begin
                  state_d = ST_WRITE;
               end
            end
         end
         ST_LOOKUP: begin
            if (rd_hit) begin
               fe_rsp_o.rvalid = 1'b1;
               fe_rsp_o.rdata  = data_q[{rd_idx, rd_off}];
               state_d         = ST_IDLE;
            end else begin
               state_d = ST_REFILL;
            end
         end
         ST_REFILL: begin
            // One word read at a time, in order
            be_req_o.valid = !wait_q;
            be_req_o.addr  = {1'b0, rd_tag, rd_idx, cnt_q};
            if (refill_word && refill_last) begin
               state_d = ST_LOOKUP; // Answer through a hit on the new line
            end
         end
         ST_WRITE: begin
            // Requester holds the write stable until ready
            be_req_o.valid = fe_req_i.valid;
            be_req_o.addr  = {1'b0, fe_req_i.addr[ADDR_W-1:0]};
            be_req_o.wdata = fe_req_i.wdata;
            be_req_o.wstrb = fe_req_i.wstrb;
            fe_rsp_o.ready = be_rsp_i.ready;
            if (fe_req_i.valid && be_rsp_i.ready) begin
               wr_accept = 1'b1;
               state_d   = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   assign refill_req  = (state_q == ST_REFILL) && be_req_o.valid && be_rsp_i.ready;
   assign refill_word = (state_q == ST_REFILL) && wait_q && be_rsp_i.rvalid;
   assign refill_last = &cnt_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q <= ST_IDLE;
         cnt_q   <= '0;
         wait_q  <= 1'b0;
         valid_q <= '0;
      end else begin
         state_q <= state_d;
         if (state_q == ST_LOOKUP) begin
            cnt_q  <= '0;
            wait_q <= 1'b0;
         end
         if (refill_req) begin
            wait_q <= 1'b1;
         end
         if (refill_word) begin
            wait_q <= 1'b0;
            cnt_q  <= cnt_q + 1'b1;
         end
         // Invalidation wins over a line completing in the same cycle
         if (inval_i || ctrl_accept) begin
            valid_q <= '0;
         end else if (refill_word && refill_last) begin
            valid_q[rd_idx] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_accept) begin
         addr_q <= fe_req_i.addr[ADDR_W-1:0];
      end
      if (refill_word) begin
         data_q[{rd_idx, cnt_q}] <= be_rsp_i.rdata;
         if (refill_last) begin
            tag_q[rd_idx] <= rd_tag;
         end
      end
      if (wr_accept && wr_hit) begin
         data_q[{wr_idx, wr_off}] <= wr_word; // Write-through, no allocate
      end
   end

endmodule

// ==== source/bus_merge2.sv ====
`timescale 1ns/1ps

module bus_merge2 import ext_mem_pkg::*; #(
   parameter type req_t = bus_req_t
) (
   input  logic     clk_i,
   input  logic     arst_i,
   input  req_t     a_req_i,
   input  req_t     b_req_i,
   output bus_rsp_t a_rsp_o,
   output bus_rsp_t b_rsp_o,
   output req_t     m_req_o,
   input  bus_rsp_t m_rsp_i
);

   logic busy_q; // Read accepted, waiting for its rvalid
   logic sel_q;  // Owner of that read, 1 for b
   logic sel;
   logic accept;

   // b has priority while idle
   assign sel = busy_q ? sel_q : b_req_i.valid;

   always_comb begin
      m_req_o = sel ? b_req_i : a_req_i;
      if (busy_q) begin
         m_req_o.valid = 1'b0; // Nothing new until the read returns
      end
   end

   assign accept = m_req_o.valid && m_rsp_i.ready;

   always_comb begin
      a_rsp_o        = '0;
      b_rsp_o        = '0;
      a_rsp_o.rdata  = m_rsp_i.rdata;
      b_rsp_o.rdata  = m_rsp_i.rdata;
      a_rsp_o.ready  = !busy_q && !sel && m_rsp_i.ready;
      b_rsp_o.ready  = !busy_q && sel && m_rsp_i.ready;
      a_rsp_o.rvalid = busy_q && !sel_q && m_rsp_i.rvalid;
      b_rsp_o.rvalid = busy_q && sel_q && m_rsp_i.rvalid;
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         busy_q <= 1'b0;
         sel_q  <= 1'b0;
      end else if (accept && (m_req_o.wstrb == '0)) begin
         busy_q <= 1'b1;
         sel_q  <= sel;
      end else if (m_rsp_i.rvalid) begin
         busy_q <= 1'b0;
      end
   end

endmodule

// ==== source/ext_mem.sv ====
`timescale 1ns/1ps
`include "ext_mem_config.svh"

module ext_mem import ext_mem_pkg::*; (
   input  logic     clk_i,
   input  logic     arst_i,
   // Instruction port
   input  bus_req_t i_req_i,
   output bus_rsp_t i_rsp_o,
   // Data port
   input  bus_req_t d_req_i,
   output bus_rsp_t d_rsp_o,
   // Memory port
   output bus_req_t mem_req_o,
   input  bus_rsp_t mem_rsp_i
);

   // L1 back ends
   bus_req_t ic_be_req;
   bus_rsp_t ic_be_rsp;
   bus_req_t dc_be_req;
   bus_rsp_t dc_be_rsp;

   // Merged bus into L2
   bus_req_t l2_req;
   bus_rsp_t l2_rsp;

   logic dc_inval;        // Pulse from a control write
   logic l2_inval_pend_q;
   logic l2_inval;

   word_cache #(
      .LINES_W (`EXT_MEM_L1_LINES_W),
      .HAS_CTRL(1'b0)
   ) icache (
      .clk_i   (clk_i),
      .arst_i  (arst_i),
      .fe_req_i(i_req_i),
      .fe_rsp_o(i_rsp_o),
      .be_req_o(ic_be_req),
      .be_rsp_i(ic_be_rsp),
      .inval_i (1'b0),      // Only reads, never flushed
      .inval_o ()
   );

   word_cache #(
      .LINES_W (`EXT_MEM_L1_LINES_W),
      .HAS_CTRL(1'b1)
   ) dcache (
      .clk_i   (clk_i),
      .arst_i  (arst_i),
      .fe_req_i(d_req_i),
      .fe_rsp_o(d_rsp_o),
      .be_req_o(dc_be_req),
      .be_rsp_i(dc_be_rsp),
      .inval_i (1'b0),
      .inval_o (dc_inval)
   );

   bus_merge2 #(
      .req_t(bus_req_t)
   ) merge (
      .clk_i  (clk_i),
      .arst_i (arst_i),
      .a_req_i(ic_be_req),
      .b_req_i(dc_be_req),
      .a_rsp_o(ic_be_rsp),
      .b_rsp_o(dc_be_rsp),
      .m_req_o(l2_req),
      .m_rsp_i(l2_rsp)
   );

   // Flush of L2 waits for a gap in its request stream
   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         l2_inval_pend_q <= 1'b0;
      end else if (dc_inval) begin
         l2_inval_pend_q <= 1'b1;
      end else if (!l2_req.valid) begin
         l2_inval_pend_q <= 1'b0;
      end
   end

   assign l2_inval = l2_inval_pend_q && !l2_req.valid;

   word_cache #(
      .LINES_W (`EXT_MEM_L2_LINES_W),
      .HAS_CTRL(1'b0)
   ) l2cache (
      .clk_i   (clk_i),
      .arst_i  (arst_i),
      .fe_req_i(l2_req),
      .fe_rsp_o(l2_rsp),
      .be_req_o(mem_req_o),
      .be_rsp_i(mem_rsp_i),
      .inval_i (l2_inval),
      .inval_o ()
   );

endmodule

// ==== verif/ext_mem_mem_model.sv ====
`timescale 1ns/1ps
`include "ext_mem_config.svh"

module ext_mem_mem_model import ext_mem_pkg::*; (
   input  logic     clk_i,
   input  logic     arst_i,
   input  bus_req_t req_i,
   output bus_rsp_t rsp_o
);

   localparam int AW = `EXT_MEM_ADDR_W;

   logic [`EXT_MEM_DATA_W-1:0] mem [1 << AW];

   logic [15:0] lfsr_q;
   logic [15:0] lfsr_d;
   logic [3:0]  rnd;      // Fresh random bits every cycle
   logic        rdy_q;
   logic        pend_q;   // Read accepted, answer still owed
   logic [1:0]  lat_q;
   logic        rvalid_q;
   logic [31:0] rdata_q;
   logic        accept;

   function automatic logic [15:0] shift_lfsr(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   always_comb begin
      lfsr_d = lfsr_q;
      for (int i = 0; i < 4; i++) begin
         lfsr_d = shift_lfsr(lfsr_d);
         rnd[i] = lfsr_d[0];
      end
   end

   assign rsp_o  = {rdy_q && !pend_q, rvalid_q, rdata_q};
   assign accept = req_i.valid && rdy_q && !pend_q;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         lfsr_q   <= 16'd70;
         rdy_q    <= 1'b0;
         pend_q   <= 1'b0;
         lat_q    <= '0;
         rvalid_q <= 1'b0;
         rdata_q  <= '0;
      end else begin
         lfsr_q   <= lfsr_d;
         rdy_q    <= rnd[0] | rnd[1]; // Ready about three cycles in four
         rvalid_q <= 1'b0;
         if (accept && (req_i.wstrb == '0)) begin
            pend_q  <= 1'b1;
            lat_q   <= rnd[3:2];
            rdata_q <= mem[req_i.addr[AW-1:0]];
         end else if (pend_q) begin
            if (lat_q == 2'd0) begin
               rvalid_q <= 1'b1;
               pend_q   <= 1'b0;
            end else begin
               lat_q <= lat_q - 2'd1;
            end
         end
      end
   end

   // Byte-masked writes from the bus
   always @(posedge clk_i) begin
      if (accept && (req_i.wstrb != '0)) begin
         for (int b = 0; b < 4; b++) begin
            if (req_i.wstrb[b]) begin
               mem[req_i.addr[AW-1:0]][8*b +: 8] = req_i.wdata[8*b +: 8];
            end
         end
      end
   end

   // Backdoor access, bypasses the bus and every cache
   task automatic write_word(input logic [AW-1:0] addr, input logic [31:0] data);
      mem[addr] = data;
   endtask

endmodule

// ==== verif/ext_mem_tb.sv ====
`timescale 1ns/1ps
`include "ext_mem_config.svh"

module ext_mem_tb import ext_mem_pkg::*; ();

   localparam int AW      = `EXT_MEM_ADDR_W;
   localparam int N_DATA  = 1200;
   localparam int N_INSTR = 800;

   logic     clk;
   logic     arst;
   bus_req_t i_req;
   bus_rsp_t i_rsp;
   bus_req_t d_req;
   bus_rsp_t d_rsp;
   bus_req_t mem_req;
   bus_rsp_t mem_rsp;

   logic [31:0]   model [1 << AW]; // Word view the memory should hold
   logic [15:0]   lfsr = 16'd70;
   int            cycles = 0;
   int            d_reads = 0;
   int            i_reads = 0;
   int            d_rvalids = 0;
   int            i_rvalids = 0;
   logic [AW-1:0] i_addrs [$];

   ext_mem UUT (
      .clk_i    (clk),
      .arst_i   (arst),
      .i_req_i  (i_req),
      .i_rsp_o  (i_rsp),
      .d_req_i  (d_req),
      .d_rsp_o  (d_rsp),
      .mem_req_o(mem_req),
      .mem_rsp_i(mem_rsp)
   );

   ext_mem_mem_model memory (
      .clk_i (clk),
      .arst_i(arst),
      .req_i (mem_req),
      .rsp_o (mem_rsp)
   );

   always #4 clk = ~clk;

   // Worst case is roughly 60 cycles for each of 3000 operations
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= `EXT_MEM_TIMEOUT) begin
         $display("RESULT: FAIL");
         $fatal(1, "Timeout, traffic still running after %0d cycles", cycles);
      end
   end

   always @(negedge clk) begin
      if (d_rsp.rvalid) d_rvalids++;
      if (i_rsp.rvalid) i_rvalids++;
   end

   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         v    = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic logic [31:0] fill_word(input logic [AW-1:0] a);
      return {~a, a[5:0], 6'h2b, a};
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                               input logic [31:0] wdata,
                                               input logic [3:0]  wstrb);
      logic [31:0] v;
      v = old;
      for (int b = 0; b < 4; b++) begin
         if (wstrb[b]) v[8*b +: 8] = wdata[8*b +: 8];
      end
      return v;
   endfunction

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
         $display("RESULT: FAIL");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   task automatic check_idle_outputs();
      check_word("i_rsp_o ready/rvalid", {30'd0, i_rsp.ready, i_rsp.rvalid}, 32'd0);
      check_word("d_rsp_o ready/rvalid", {30'd0, d_rsp.ready, d_rsp.rvalid}, 32'd0);
      check_word("mem_req_o.valid", {31'd0, mem_req.valid}, 32'd0);
   endtask

   // Starts and ends 1 ns after a rising edge; lat counts cycles to rvalid
   task automatic data_access(input logic [AW:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output logic [31:0] rdata,
                              output int lat);
      d_req.valid = 1'b1;
      d_req.addr  = addr;
      d_req.wdata = wdata;
      d_req.wstrb = wstrb;
      do @(negedge clk); while (!d_rsp.ready);
      @(posedge clk);
      #1;
      d_req = '0;
      lat   = 0;
      rdata = '0;
      if (wstrb == '0) begin
         d_reads++;
         do begin
            @(negedge clk);
            lat++;
         end while (!d_rsp.rvalid);
         rdata = d_rsp.rdata;
         @(posedge clk);
         #1;
      end
   endtask

   // Writes stay in the lower half, so the upper half is never stale
   task automatic data_traffic();
      logic [AW-1:0] a;
      logic [31:0]   w;
      logic [31:0]   r;
      logic [3:0]    s;
      int            lat;
      for (int n = 0; n < N_DATA; n++) begin
         a = {1'b0, (AW-1)'(rand_bits(AW-1))};
         w = rand_bits(32);
         s = 4'(rand_bits(4));
         if ((rand_bits(1) != 0) && (s != 4'd0)) begin
            data_access({1'b0, a}, w, s, r, lat);
            model[a] = merge_bytes(model[a], w, s);
         end else begin
            data_access({1'b0, a}, 32'd0, 4'd0, r, lat);
            check_word("d_rsp_o.rdata", r, model[a]);
            data_access({1'b0, a}, 32'd0, 4'd0, r, lat); // Line is now present
            check_word("d_rsp_o.rdata on hit", r, model[a]);
            check_word("d_rsp_o hit latency", 32'(lat), 32'd1);
         end
      end
   endtask

   task automatic instr_traffic();
      logic [AW-1:0] a;
      logic [31:0]   r;
      while (i_addrs.size() > 0) begin
         a           = i_addrs.pop_front();
         i_req.valid = 1'b1;
         i_req.addr  = {1'b0, a};
         i_req.wdata = '0;
         i_req.wstrb = '0;
         do @(negedge clk); while (!i_rsp.ready);
         @(posedge clk);
         #1;
         i_req = '0;
         i_reads++;
         do @(negedge clk); while (!i_rsp.rvalid);
         r = i_rsp.rdata;
         @(posedge clk);
         #1;
         check_word("i_rsp_o.rdata", r, model[a]);
      end
   endtask

   initial begin
      logic [AW-1:0] a;
      logic [AW-1:0] a_evict;
      logic [31:0]   r;
      logic [31:0]   stale;
      int            lat;
      clk   = 1'b0;
      arst  = 1'b1;
      i_req = '0;
      d_req = '0;
      for (int k = 0; k < (1 << AW); k++) begin
         model[k] = fill_word(AW'(k));
         memory.write_word(AW'(k), model[k]);
      end
      repeat (16) begin
         @(negedge clk);
         check_idle_outputs();
      end
      @(posedge clk);
      #1;
      arst = 1'b0;
      repeat (3) begin
         @(negedge clk);
         check_idle_outputs();
      end
      @(posedge clk);
      #1;

      for (int n = 0; n < N_INSTR; n++) begin
         i_addrs.push_back({1'b1, (AW-1)'(rand_bits(AW-1))});
      end
      fork
         data_traffic();
         instr_traffic();
      join

      // Backdoor change that dcache and L2 hide until flushed
      a       = {1'b0, (AW-1)'(rand_bits(AW-1))};
      a_evict = a ^ AW'(1 << (`EXT_MEM_WORD_OFF_W + `EXT_MEM_L1_LINES_W)); // Same dcache line
      data_access({1'b0, a_evict}, 32'd0, 4'd0, r, lat);
      check_word("d_rsp_o.rdata evicting read", r, model[a_evict]);
      data_access({1'b0, a}, 32'd0, 4'd0, r, lat);
      check_word("d_rsp_o.rdata before backdoor", r, model[a]);
      stale    = model[a];
      model[a] = ~stale;
      memory.write_word(a, model[a]);
      data_access({1'b0, a}, 32'd0, 4'd0, r, lat);
      check_word("d_rsp_o.rdata dcache view", r, stale);
      data_access({1'b0, a_evict}, 32'd0, 4'd0, r, lat); // Evicts a from dcache only
      check_word("d_rsp_o.rdata evicting read", r, model[a_evict]);
      data_access({1'b0, a}, 32'd0, 4'd0, r, lat);
      check_word("d_rsp_o.rdata L2 view", r, stale);
      data_access({1'b1, a}, 32'hffff_ffff, 4'hf, r, lat); // Control space write
      data_access({1'b0, a}, 32'd0, 4'd0, r, lat);
      check_word("d_rsp_o.rdata after invalidate", r, model[a]);

      repeat (4) @(posedge clk);
      check_word("d_rsp_o.rvalid count", d_rvalids, d_reads);
      check_word("i_rsp_o.rvalid count", i_rvalids, i_reads);
      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+include
source/ext_mem_pkg.sv
source/word_cache.sv
source/bus_merge2.sv
source/ext_mem.sv
verif/ext_mem_mem_model.sv
verif/ext_mem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module ext_mem_tb -f build.f -o ext_mem_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/ext_mem_sim
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi
exit 0
